/* filelist.f */
hdl/llink_pkg.sv
hdl/ll_auto_sync.sv
hdl/chan_map.sv
hdl/phy_word_map.sv
hdl/fourchan_link_top.sv
verif/tb_fourchan_link.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the four-channel link testbench with Verilator, run it, check the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fourchan_link \
  -f filelist.f -o tb_sim || { echo "Build failed"; exit 1; }

sim_out=$(./obj_dir/tb_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "NO ERRORS" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* verif/tb_fourchan_link.sv */
/*
  Directed testbench for the four-channel link top level
  Clock, reset and watchdog
  One task per behavior, then the closing report
*/
`timescale 1ns/10ps

module tb_fourchan_link;

  import llink_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 2;
  // Compare width, everything is widened to a PHY word
  localparam int VW         = PHY_WIDTH;
  localparam int DLY_X      = 5;
  localparam int DLY_Y      = 3;
  localparam int DLY_Z      = 3;
  localparam int N_WORDS    = 8;
  // Cycle budget per test
  localparam int T_RESET    = 8;
  localparam int T_DELAY    = 24;
  localparam int T_GEN2     = 40;
  localparam int T_GEN1     = 40;
  localparam int T_USERBITS = 48;
  localparam int T_OFFLINE  = 40;
  localparam int MARGIN     = 200;
  localparam int WDOG_CYCLES = T_RESET + T_DELAY + T_GEN2 + T_GEN1 + T_USERBITS
                               + T_OFFLINE + MARGIN;

  logic                 clk;
  logic                 arst_n;
  logic                 tx_online;
  logic                 rx_online;
  logic                 m_gen2_mode;
  logic [MRK_WIDTH-1:0] tx_mrk_userbit;
  logic                 tx_stb_userbit;
  logic [15:0]          delay_x_value;
  logic [15:0]          delay_y_value;
  logic [15:0]          delay_z_value;
  chan_data_t           ch_tx_data [NUM_CH];
  chan_data_t           ch_rx_data [NUM_CH];
  phy_word_t            tx_phy;
  phy_word_t            rx_phy;
  logic [31:0]          debug_status;

  int          err_cnt;
  int          test_cnt;

  fourchan_link_top #(.DLY_WIDTH(16)) dut (
    .clk_wr(clk), .arst_n(arst_n),
    .tx_online(tx_online), .rx_online(rx_online), .m_gen2_mode(m_gen2_mode),
    .tx_mrk_userbit(tx_mrk_userbit), .tx_stb_userbit(tx_stb_userbit),
    .delay_x_value(delay_x_value), .delay_y_value(delay_y_value),
    .delay_z_value(delay_z_value),
    .ch_tx_data(ch_tx_data), .ch_rx_data(ch_rx_data),
    .tx_phy(tx_phy), .rx_phy(rx_phy), .debug_status(debug_status)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clock and watchdog

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, run stopped", WDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  // Outputs settled, inputs may change
  task automatic tick();
    @(posedge clk);
    #(DRIVE_DLY);
  endtask

  task automatic check_value(input string sig, input logic [VW-1:0] got,
                             input logic [VW-1:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s got %h expected %h", sig, got, exp);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    test_cnt++;
    $display("Test %-14s done, %0d errors", name, err_cnt - err_start);
  endtask

  // Expected debug word, bit 19 tx and bit 18 rx
  function automatic logic [31:0] status_word(input logic tx_up, input logic rx_up);
    logic [31:0] w;
    w     = '0;
    w[19] = tx_up;
    w[18] = rx_up;
    return w;
  endfunction

  function automatic chan_data_t rand_chan();
    logic [95:0] r;
    r = {$urandom, $urandom, $urandom};
    return r[CH_WIDTH-1:0];
  endfunction

  // Whole PHY word random, spare and userbits included
  function automatic phy_word_t rand_phy();
    logic [PHY_WIDTH-1:0] r;
    for (int k = 0; k < PHY_WIDTH / 32; k++) begin
      r[k*32 +: 32] = $urandom;
    end
    return phy_word_t'(r);
  endfunction

  task automatic check_idle();
    check_value("tx_phy", VW'(tx_phy), VW'(1'b0));
    for (int i = 0; i < NUM_CH; i++) begin
      check_value($sformatf("ch_rx_data[%0d]", i), VW'(ch_rx_data[i]), VW'(1'b0));
    end
    check_value("debug_status", VW'(debug_status), VW'(1'b0));
  endtask

  // Raise both online levels, wait for both delayed levels
  task automatic bring_online();
    int wait_cnt;
    wait_cnt  = 0;
    tx_online = 1'b1;
    rx_online = 1'b1;
    while (debug_status[19:18] != 2'b11 && wait_cnt < 32) begin
      tick();
      wait_cnt++;
    end
    assert (debug_status[19:18] == 2'b11) else begin
      $display("Link did not come online within %0d cycles", wait_cnt);
      err_cnt++;
    end
  endtask

  // Random words both ways, upper channels expected zero in gen1
  task automatic stream_words(input logic gen2);
    chan_data_t sent;
    link_word_t exp_tx;
    link_word_t exp_rx;
    phy_word_t  rx_word;
    for (int w = 0; w < N_WORDS; w++) begin
      rx_word = rand_phy();
      rx_phy  = rx_word;
      for (int i = 0; i < NUM_CH; i++) begin
        sent          = rand_chan();
        ch_tx_data[i] = sent;
        exp_tx[i]     = (gen2 || i < 2) ? sent : '0;
        exp_rx[i]     = (gen2 || i < 2) ? rx_word.data[i] : '0;
      end
      tick();
      for (int i = 0; i < NUM_CH; i++) begin
        check_value($sformatf("tx_phy.data[%0d]", i), VW'(tx_phy.data[i]), VW'(exp_tx[i]));
        check_value($sformatf("ch_rx_data[%0d]", i), VW'(ch_rx_data[i]), VW'(exp_rx[i]));
      end
      check_value("tx_phy.spare", VW'(tx_phy.spare), VW'(1'b0));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests

  task automatic test_reset_state();
    int err_start;
    err_start = err_cnt;
    // Online high all through reset
    for (int c = 0; c < 2; c++) begin
      rx_phy = rand_phy();
      tick();
      check_idle();
    end
    arst_n = 1'b1;
    // rx level is first up, at edge DLY_Y+1
    for (int n = 1; n <= DLY_Y; n++) begin
      rx_phy = rand_phy();
      tick();
      check_idle();
    end
    finish_test("reset_state", err_start);
  endtask

  task automatic test_online_delay();
    int err_start;
    err_start = err_cnt;
    tx_online = 1'b0;
    rx_online = 1'b0;
    tick();
    check_value("debug_status", VW'(debug_status), VW'(status_word(1'b0, 1'b0)));
    tx_online = 1'b1;
    rx_online = 1'b1;
    // Edge n is the nth edge that samples online high
    for (int n = 1; n <= DLY_X + 3; n++) begin
      tick();
      check_value("debug_status", VW'(debug_status),
                  VW'(status_word(n >= DLY_X + 1, n >= DLY_Y + 1)));
    end
    tx_online = 1'b0;
    tick();
    check_value("debug_status", VW'(debug_status), VW'(status_word(1'b0, 1'b1)));
    rx_online = 1'b0;
    tick();
    check_value("debug_status", VW'(debug_status), VW'(status_word(1'b0, 1'b0)));
    finish_test("online_delay", err_start);
  endtask

  task automatic test_gen2_loopback();
    int err_start;
    err_start   = err_cnt;
    m_gen2_mode = 1'b1;
    bring_online();
    stream_words(1'b1);
    finish_test("gen2_loopback", err_start);
  endtask

  task automatic test_gen1_masking();
    int err_start;
    err_start   = err_cnt;
    m_gen2_mode = 1'b0;
    tick();
    stream_words(1'b0);
    finish_test("gen1_masking", err_start);
  endtask

  task automatic test_userbits();
    int                   err_start;
    int                   first_word;
    int                   w;
    logic [MRK_WIDTH-1:0] cur_mrk;
    logic                 cur_stb;
    logic                 exp_stb;
    err_start   = err_cnt;
    m_gen2_mode = 1'b1;
    // Offline first so the strobe phase starts fresh
    tx_online = 1'b0;
    tick();
    cur_mrk        = MRK_WIDTH'($urandom);
    cur_stb        = 1'b1;
    tx_mrk_userbit = cur_mrk;
    tx_stb_userbit = cur_stb;
    tx_online      = 1'b1;
    // Level up at edge DLY_X+1, its first word one edge later
    first_word = DLY_X + 2;
    for (int n = 1; n <= first_word + 12; n++) begin
      tick();
      w = n - first_word;
      if (w < 0) begin
        check_value("tx_phy", VW'(tx_phy), VW'(1'b0));
      end else begin
        exp_stb = (w % (DLY_Z + 1) == 0) ? cur_stb : 1'b0;
        check_value("tx_phy.stb", VW'(tx_phy.stb), VW'(exp_stb));
        check_value("tx_phy.mrk", VW'(tx_phy.mrk), VW'(cur_mrk));
      end
      check_value("tx_phy.spare", VW'(tx_phy.spare), VW'(1'b0));
      // New userbits every cycle, strobe mostly high
      cur_mrk        = MRK_WIDTH'($urandom);
      cur_stb        = ($urandom % 4) != 0;
      tx_mrk_userbit = cur_mrk;
      tx_stb_userbit = cur_stb;
    end
    finish_test("userbits", err_start);
  endtask

  task automatic test_offline();
    int err_start;
    err_start   = err_cnt;
    m_gen2_mode = 1'b1;
    bring_online();
    tx_online = 1'b0;
    // One last word from the online cycle, blank after
    for (int n = 1; n <= 4; n++) begin
      for (int i = 0; i < NUM_CH; i++) begin
        ch_tx_data[i] = rand_chan();
      end
      tick();
      if (n >= 2) begin
        check_value("tx_phy", VW'(tx_phy), VW'(1'b0));
      end
    end
    rx_online = 1'b0;
    // rx_phy keeps carrying data
    for (int n = 1; n <= 4; n++) begin
      rx_phy = rand_phy();
      tick();
      if (n >= 2) begin
        for (int i = 0; i < NUM_CH; i++) begin
          check_value($sformatf("ch_rx_data[%0d]", i), VW'(ch_rx_data[i]), VW'(1'b0));
        end
      end
    end
    finish_test("offline", err_start);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    void'($urandom(32'he414));
    err_cnt        = 0;
    test_cnt       = 0;
    arst_n         = 1'b0;
    tx_online      = 1'b1;
    rx_online      = 1'b1;
    m_gen2_mode    = 1'b1;
    tx_mrk_userbit = '0;
    tx_stb_userbit = 1'b0;
    delay_x_value  = 16'(DLY_X);
    delay_y_value  = 16'(DLY_Y);
    delay_z_value  = 16'(DLY_Z);
    rx_phy         = '0;
    for (int i = 0; i < NUM_CH; i++) begin
      ch_tx_data[i] = '0;
    end

    test_reset_state();
    test_online_delay();
    test_gen2_loopback();
    test_gen1_masking();
    test_userbits();
    test_offline();

    $display("Summary: %0d tests run, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* hdl/fourchan_link_top.sv */
/*
  Four-channel link framing, master side
  Auto-sync, channel map and PHY word map
*/
`timescale 1ns/10ps

module fourchan_link_top #(
  parameter int DLY_WIDTH = 16
) (
  input  logic                            clk_wr,
  input  logic                            arst_n,
  // Link control
  input  logic                            tx_online,
  input  logic                            rx_online,
  input  logic                            m_gen2_mode,
  input  logic [llink_pkg::MRK_WIDTH-1:0] tx_mrk_userbit,
  input  logic                            tx_stb_userbit,
  input  logic [DLY_WIDTH-1:0]            delay_x_value,
  input  logic [DLY_WIDTH-1:0]            delay_y_value,
  input  logic [DLY_WIDTH-1:0]            delay_z_value,
  // User channels
  input  llink_pkg::chan_data_t           ch_tx_data [llink_pkg::NUM_CH],
  output llink_pkg::chan_data_t           ch_rx_data [llink_pkg::NUM_CH],
  // PHY side
  output llink_pkg::phy_word_t            tx_phy,
  input  llink_pkg::phy_word_t            rx_phy,
  output logic [31:0]                     debug_status
);

  import llink_pkg::*;

  logic       tx_online_dly;
  logic       rx_online_dly;
  userbits_t  tx_userbits;
  link_word_t tx_link;
  link_word_t rx_link;

  ////////////////////////////////////////////////////////////////////////////
  // Auto-sync

  ll_auto_sync #(.DLY_WIDTH(DLY_WIDTH)) u_auto_sync (
    .clk_wr(clk_wr), .arst_n(arst_n),
    .tx_online(tx_online), .rx_online(rx_online),
    .delay_x_value(delay_x_value), .delay_y_value(delay_y_value),
    .delay_z_value(delay_z_value),
    .tx_mrk_userbit(tx_mrk_userbit), .tx_stb_userbit(tx_stb_userbit),
    .tx_online_dly(tx_online_dly), .rx_online_dly(rx_online_dly),
    .tx_userbits(tx_userbits), .debug_status(debug_status)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Channel map and PHY word map

  chan_map u_chan_map (
    .m_gen2_mode(m_gen2_mode),
    .ch_tx_data(ch_tx_data), .rx_link(rx_link),
    .ch_rx_data(ch_rx_data), .tx_link(tx_link)
  );

  // Both directions registered here
  phy_word_map u_phy_map (
    .clk_wr(clk_wr), .arst_n(arst_n),
    .tx_online_dly(tx_online_dly), .rx_online_dly(rx_online_dly),
    .tx_link(tx_link), .tx_userbits(tx_userbits), .rx_phy(rx_phy),
    .tx_phy(tx_phy), .rx_link(rx_link)
  );

endmodule

/* hdl/phy_word_map.sv */
/*
  Transmit PHY word assembly and register
  Receive data field extraction and register
*/
`timescale 1ns/10ps

module phy_word_map (
  input  logic                   clk_wr,
  input  logic                   arst_n,
  input  logic                   tx_online_dly,
  input  logic                   rx_online_dly,
  input  llink_pkg::link_word_t  tx_link,
  input  llink_pkg::userbits_t   tx_userbits,
  input  llink_pkg::phy_word_t   rx_phy,
  output llink_pkg::phy_word_t   tx_phy,
  output llink_pkg::link_word_t  rx_link
);

  import llink_pkg::*;

  phy_word_t  tx_word_d;
  link_word_t rx_data_d;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit path

  // Whole word zero while tx is offline
  always_comb begin
    tx_word_d = '0;
    if (tx_online_dly) begin
      tx_word_d.mrk  = tx_userbits.mrk;
      tx_word_d.stb  = tx_userbits.stb;
      tx_word_d.data = tx_link;
    end
  end

  // One cycle from channel inputs to the PHY
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_word_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive path

  // Only the data field goes on
  assign rx_data_d = rx_online_dly ? rx_phy.data : '0;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_link <= '0;
    end else begin
      rx_link <= rx_data_d;
    end
  end

  // Spare field never toggles
  a_spare_zero: assert property (@(posedge clk_wr) disable iff (!arst_n)
    tx_phy.spare == '0);

endmodule

/* hdl/chan_map.sv */
/*
  User channel to link word mapping, both directions
  Gen1 masking of channels 2 and 3
*/
`timescale 1ns/10ps

module chan_map (
  input  logic                   m_gen2_mode,
  input  llink_pkg::chan_data_t  ch_tx_data [llink_pkg::NUM_CH],
  input  llink_pkg::link_word_t  rx_link,
  output llink_pkg::chan_data_t  ch_rx_data [llink_pkg::NUM_CH],
  output llink_pkg::link_word_t  tx_link
);

  import llink_pkg::*;

  // Channels that carry data in gen1
  localparam int GEN1_CH = 2;

  logic [NUM_CH-1:0] ch_en;

  ////////////////////////////////////////////////////////////////////////////
  // Channel enables

  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      // Gen2 opens every channel
      ch_en[i] = m_gen2_mode || (i < GEN1_CH);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Per channel mapping

  for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
    // Channel i lands at bits i*CH_WIDTH up
    assign tx_link[i] = ch_en[i] ? ch_tx_data[i] : '0;

    // Masked channels read as zero
    assign ch_rx_data[i] = ch_en[i] ? rx_link[i] : '0;
  end

endmodule

/* hdl/ll_auto_sync.sv */
/*
  Online delay counters for tx and rx
  Strobe period counter and marker gating
  Debug status word with both delayed online levels
*/
`timescale 1ns/10ps

module ll_auto_sync #(
  parameter int DLY_WIDTH = 16
) (
  input  logic                           clk_wr,
  input  logic                           arst_n,
  input  logic                           tx_online,
  input  logic                           rx_online,
  input  logic [DLY_WIDTH-1:0]           delay_x_value,
  input  logic [DLY_WIDTH-1:0]           delay_y_value,
  input  logic [DLY_WIDTH-1:0]           delay_z_value,
  input  logic [llink_pkg::MRK_WIDTH-1:0] tx_mrk_userbit,
  input  logic                           tx_stb_userbit,
  output logic                           tx_online_dly,
  output logic                           rx_online_dly,
  output llink_pkg::userbits_t           tx_userbits,
  output logic [31:0]                    debug_status
);

  ////////////////////////////////////////////////////////////////////////////
  // Online delay, lane 0 is tx and lane 1 is rx

  logic                 online_in    [2];
  logic [DLY_WIDTH-1:0] dly_limit    [2];
  logic [DLY_WIDTH-1:0] dly_cnt      [2];
  logic                 online_dly_q [2];
  logic [DLY_WIDTH-1:0] stb_cnt;
  logic                 stb_slot;

  assign online_in[0] = tx_online;
  assign online_in[1] = rx_online;
  assign dly_limit[0] = delay_x_value;
  assign dly_limit[1] = delay_y_value;

  for (genvar i = 0; i < 2; i++) begin : g_dly
    // Count held edges, level goes up on edge limit+1
    always_ff @(posedge clk_wr or negedge arst_n) begin
      if (!arst_n) begin
        dly_cnt[i]      <= '0;
        online_dly_q[i] <= 1'b0;
      end else if (!online_in[i]) begin
        dly_cnt[i]      <= '0;
        online_dly_q[i] <= 1'b0;
      end else if (dly_cnt[i] == dly_limit[i]) begin
        // Counter parks at the limit
        online_dly_q[i] <= 1'b1;
      end else begin
        dly_cnt[i] <= dly_cnt[i] + 1'b1;
      end
    end
  end

  assign tx_online_dly = online_dly_q[0];
  assign rx_online_dly = online_dly_q[1];

  ////////////////////////////////////////////////////////////////////////////
  // Strobe period, modulo delay_z_value+1

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      stb_cnt <= '0;
    end else if (!tx_online_dly || stb_cnt == delay_z_value) begin
      stb_cnt <= '0;
    end else begin
      stb_cnt <= stb_cnt + 1'b1;
    end
  end

  // Slot zero of each period, first online cycle included
  assign stb_slot = tx_online_dly && (stb_cnt == '0);

  always_comb begin
    tx_userbits.mrk = tx_online_dly ? tx_mrk_userbit : '0;
    tx_userbits.stb = stb_slot ? tx_stb_userbit : 1'b0;
  end

  // Bit 19 tx level, bit 18 rx level
  assign debug_status = {12'h0, tx_online_dly, rx_online_dly, 18'h0};

  // Nothing leaves on the userbits while offline
  a_ub_quiet: assert property (@(posedge clk_wr) disable iff (!arst_n)
    !tx_online_dly |-> (tx_userbits == '0));

  // Delay limits hold still while their online level stays up
  a_dly_x_steady: assert property (@(posedge clk_wr) disable iff (!arst_n)
    (tx_online && $past(tx_online)) |-> $stable(delay_x_value));

  a_dly_y_steady: assert property (@(posedge clk_wr) disable iff (!arst_n)
    (rx_online && $past(rx_online)) |-> $stable(delay_y_value));

endmodule

/* hdl/llink_pkg.sv */
/*
  Link geometry for the four-channel die-to-die link
  Channel word, link word and userbit types
  PHY word layout with spare, marker, strobe and data fields
*/
package llink_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths

  // Four user channels, 74 bits each
  parameter int NUM_CH     = 4;
  parameter int CH_WIDTH   = 74;
  // Data field of the PHY word
  parameter int LINK_WIDTH = NUM_CH * CH_WIDTH;
  parameter int PHY_WIDTH  = 320;
  parameter int MRK_WIDTH  = 4;

  // Whatever is left above mrk and stb
  localparam int SPARE_WIDTH = PHY_WIDTH - LINK_WIDTH - MRK_WIDTH - 1;

  ////////////////////////////////////////////////////////////////////////////
  // Types

  typedef logic [CH_WIDTH-1:0] chan_data_t;

  // Channel 0 in the low bits
  typedef chan_data_t [NUM_CH-1:0] link_word_t;

  typedef struct packed {
    logic [MRK_WIDTH-1:0] mrk;
    logic                 stb;
  } userbits_t;

  // Top down: spare, marker, strobe, data
  typedef struct packed {
    logic [SPARE_WIDTH-1:0] spare;
    logic [MRK_WIDTH-1:0]   mrk;
    logic                   stb;
    link_word_t             data;
  } phy_word_t;

endpackage
